//--- design/ex_consts.svh
// --------------------
// widths and reset PC of the execute core.
// PC and data share one width, and addresses count words.
// --------------------
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// data and pc width.
`define EX_XLEN 16

// register file size and the width of a register index.
`define EX_NREGS 8
`define EX_RADDR_W 3

// first pc the execute stage accepts.
`define EX_RESET_PC 16'h0000

`endif

//--- design/ex_isa_pkg.sv
// --------------------
// ISA view of the 16-bit core. Opcode sits in bits 15..12.
// Opcode 15 is the only illegal encoding.
// --------------------
`default_nettype none

package ex_isa_pkg;

   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLL  = 4'd5,
      OP_SRL  = 4'd6,
      OP_SRA  = 4'd7,
      OP_ADDI = 4'd8,   // rd = rs + simm6.
      OP_BEQZ = 4'd9,
      OP_BNEZ = 4'd10,
      OP_BLTZ = 4'd11,
      OP_BGEZ = 4'd12,
      OP_J    = 4'd13,  // pc+1 + simm9.
      OP_JR   = 4'd14,  // rs + simm6.
      OP_ILL  = 4'd15
   } opcode_e;

   // subtract is add with inverted b and carry in.
   typedef enum logic [2:0] {
      ALU_ADD, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_A
   } alu_op_e;

   // all conditions look at rs only.
   typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_GE} br_cond_e;

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;   // also upper bits of simm6.
      logic [2:0] lo;
   } instr_t;

endpackage

`default_nettype wire

//--- design/ex_pipe_pkg.sv
// --------------------
// records passed between decode, execute and result.
// new_pc holds pc+1 when no redirect is taken.
// --------------------
`default_nettype none

`include "ex_consts.svh"

package ex_pipe_pkg;

   typedef struct packed {
      logic [`EX_XLEN-1:0]    pc;
      logic [`EX_RADDR_W-1:0] rd;
      logic [`EX_RADDR_W-1:0] rs;
      logic [`EX_RADDR_W-1:0] rt;
      logic [`EX_XLEN-1:0]    sext_imm;
      ex_isa_pkg::alu_op_e    alu_op;
      logic                   inv_b;
      logic                   cin;
      logic                   use_imm;        // b from immediate, not rt.
      logic                   br_instr;
      ex_isa_pkg::br_cond_e   br_cond;
      logic                   jmp_instr;
      logic                   jmp_reg_instr;
      logic                   we;
      logic                   ofl_en;
      logic                   err;            // illegal opcode.
   } dec_t;

   typedef struct packed {
      logic [`EX_XLEN-1:0]    pc;
      logic [`EX_RADDR_W-1:0] rd;
      logic                   we;
      logic [`EX_XLEN-1:0]    value;
      logic                   ofl;
      logic                   redirect;
      logic [`EX_XLEN-1:0]    new_pc;
      logic                   err;
   } res_t;

endpackage

`default_nettype wire

//--- design/ex_pipe_reg.sv
// --------------------
// one-entry valid/ready register.
// full entry can be replaced in the cycle it leaves.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module ex_pipe_reg #(
   parameter type payload_t = logic
) (
   input  wire logic clk,
   input  wire logic arst_n,
   input  wire logic in_valid,
   output logic      in_ready,
   input  payload_t  in_data,
   output logic      out_valid,
   input  wire logic out_ready,
   output payload_t  out_data
);

   assign in_ready = ~out_valid | out_ready;   // empty or draining.

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   // payload only moves on an accepted transfer.
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out_data <= in_data;
      end
   end

endmodule

`default_nettype wire

//--- design/ex_decode.sv
// --------------------
// pure decode, no state.
// simm6 is bits 5..0, simm9 is bits 8..0.
// --------------------
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_decode (
   input  ex_isa_pkg::instr_t       instr,
   input  wire logic [`EX_XLEN-1:0] pc,
   output ex_pipe_pkg::dec_t        dec
);

   import ex_isa_pkg::*;

   logic [`EX_XLEN-1:0] simm6;
   logic [`EX_XLEN-1:0] simm9;

   assign simm6 = {{(`EX_XLEN-6){instr.rt[2]}}, instr.rt, instr.lo};
   assign simm9 = {{(`EX_XLEN-9){instr.rs[2]}}, instr.rs, instr.rt, instr.lo};

   always_comb begin
      dec          = '0;
      dec.pc       = pc;
      dec.rd       = instr.rd;
      dec.rs       = instr.rs;
      dec.rt       = instr.rt;
      dec.sext_imm = simm6;
      dec.alu_op   = ALU_PASS_A;
      dec.br_cond  = BR_EQ;

      case (instr.opcode)
         OP_ADD: begin
            dec.alu_op = ALU_ADD;
            dec.we     = 1'b1;
            dec.ofl_en = 1'b1;
         end
         OP_SUB: begin
            dec.alu_op = ALU_ADD;   // a + ~b + 1.
            dec.inv_b  = 1'b1;
            dec.cin    = 1'b1;
            dec.we     = 1'b1;
            dec.ofl_en = 1'b1;
         end
         OP_AND: begin
            dec.alu_op = ALU_AND;
            dec.we     = 1'b1;
         end
         OP_OR: begin
            dec.alu_op = ALU_OR;
            dec.we     = 1'b1;
         end
         OP_XOR: begin
            dec.alu_op = ALU_XOR;
            dec.we     = 1'b1;
         end
         OP_SLL: begin
            dec.alu_op = ALU_SLL;
            dec.we     = 1'b1;
         end
         OP_SRL: begin
            dec.alu_op = ALU_SRL;
            dec.we     = 1'b1;
         end
         OP_SRA: begin
            dec.alu_op = ALU_SRA;
            dec.we     = 1'b1;
         end
         OP_ADDI: begin
            dec.alu_op  = ALU_ADD;
            dec.use_imm = 1'b1;
            dec.we      = 1'b1;
            dec.ofl_en  = 1'b1;
         end
         // branches test rs through pass-a.
         OP_BEQZ: dec.br_instr = 1'b1;
         OP_BNEZ: begin
            dec.br_instr = 1'b1;
            dec.br_cond  = BR_NE;
         end
         OP_BLTZ: begin
            dec.br_instr = 1'b1;
            dec.br_cond  = BR_LT;
         end
         OP_BGEZ: begin
            dec.br_instr = 1'b1;
            dec.br_cond  = BR_GE;
         end
         OP_J: begin
            dec.jmp_instr = 1'b1;
            dec.sext_imm  = simm9;
         end
         OP_JR: begin
            dec.alu_op        = ALU_ADD;   // target is rs + simm6.
            dec.use_imm       = 1'b1;
            dec.jmp_reg_instr = 1'b1;
         end
         default: dec.err = 1'b1;   // opcode 15, we stays clear.
      endcase
   end

endmodule

`default_nettype wire

//--- design/ex_alu.sv
// --------------------
// 16-bit ALU. Shifts use b bits 3..0.
// ofl is valid only for the add path.
// --------------------
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_alu (
   input  wire logic [`EX_XLEN-1:0] a,
   input  wire logic [`EX_XLEN-1:0] b,
   input  ex_isa_pkg::alu_op_e      op,
   input  wire logic                inv_b,
   input  wire logic                cin,
   output logic [`EX_XLEN-1:0]      out,
   output logic                     zero,
   output logic                     ofl
);

   import ex_isa_pkg::*;

   logic [`EX_XLEN-1:0] b_eff;
   logic [`EX_XLEN-1:0] sum;
   logic [3:0]          shamt;

   assign b_eff = inv_b ? ~b : b;
   assign sum   = a + b_eff + {{(`EX_XLEN-1){1'b0}}, cin};
   assign shamt = b[3:0];

   always_comb begin
      case (op)
         ALU_ADD: out = sum;
         ALU_AND: out = a & b_eff;
         ALU_OR:  out = a | b_eff;
         ALU_XOR: out = a ^ b_eff;
         ALU_SLL: out = a << shamt;
         ALU_SRL: out = a >> shamt;
         ALU_SRA: out = $signed(a) >>> shamt;   // sign fill.
         default: out = a;                       // pass-a.
      endcase
   end

   assign zero = (out == '0);

   // same operand signs but a result of the other sign.
   assign ofl = (a[`EX_XLEN-1] == b_eff[`EX_XLEN-1]) &
                (sum[`EX_XLEN-1] != a[`EX_XLEN-1]);

endmodule

`default_nettype wire

//--- design/ex_execute.sv
// --------------------
// forwards only from the result register.
// off-path entries are dropped without a record.
// --------------------
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_execute (
   input  wire logic                   clk,
   input  wire logic                   arst_n,
   input  ex_pipe_pkg::dec_t           dec_in,
   input  wire logic                   dec_valid,
   output logic                        dec_ready,
   output logic [`EX_RADDR_W-1:0]      rs_addr,
   output logic [`EX_RADDR_W-1:0]      rt_addr,
   input  wire logic [`EX_XLEN-1:0]    rs_val,
   input  wire logic [`EX_XLEN-1:0]    rt_val,
   input  wire logic                   fwd_valid,
   input  ex_pipe_pkg::res_t           fwd,
   output ex_pipe_pkg::res_t           res_out,
   output logic                        res_valid,
   input  wire logic                   res_ready
);

   import ex_isa_pkg::*;

   logic [`EX_XLEN-1:0] op_a;
   logic [`EX_XLEN-1:0] op_t;
   logic [`EX_XLEN-1:0] op_b;
   logic [`EX_XLEN-1:0] alu_out;
   logic [`EX_XLEN-1:0] pc_inc;
   logic [`EX_XLEN-1:0] target;
   logic [`EX_XLEN-1:0] expected_pc;
   logic                alu_zero;
   logic                alu_ofl;
   logic                take_br;
   logic                redirect;
   logic                on_path;
   logic                fwd_hit_rs;
   logic                fwd_hit_rt;

   assign rs_addr = dec_in.rs;
   assign rt_addr = dec_in.rt;

   // the waiting result is the only value not yet in the register file.
   assign fwd_hit_rs = fwd_valid & fwd.we & (fwd.rd == dec_in.rs);
   assign fwd_hit_rt = fwd_valid & fwd.we & (fwd.rd == dec_in.rt);

   assign op_a = fwd_hit_rs ? fwd.value : rs_val;
   assign op_t = fwd_hit_rt ? fwd.value : rt_val;
   assign op_b = dec_in.use_imm ? dec_in.sext_imm : op_t;

   ex_alu u_alu (
      .a     (op_a),
      .b     (op_b),
      .op    (dec_in.alu_op),
      .inv_b (dec_in.inv_b),
      .cin   (dec_in.cin),
      .out   (alu_out),
      .zero  (alu_zero),
      .ofl   (alu_ofl)
   );

   always_comb begin
      case (dec_in.br_cond)
         BR_EQ:   take_br = alu_zero;
         BR_NE:   take_br = ~alu_zero;
         BR_LT:   take_br = op_a[`EX_XLEN-1];
         default: take_br = ~op_a[`EX_XLEN-1];
      endcase
   end

   assign pc_inc   = dec_in.pc + {{(`EX_XLEN-1){1'b0}}, 1'b1};
   assign redirect = dec_in.jmp_instr | dec_in.jmp_reg_instr | (dec_in.br_instr & take_br);
   assign target   = dec_in.jmp_reg_instr ? alu_out : pc_inc + dec_in.sext_imm;

   always_comb begin
      res_out.pc       = dec_in.pc;
      res_out.rd       = dec_in.rd;
      res_out.we       = dec_in.we;
      res_out.value    = alu_out;
      res_out.ofl      = alu_ofl & dec_in.ofl_en;
      res_out.redirect = redirect;
      res_out.new_pc   = redirect ? target : pc_inc;   // next pc either way.
      res_out.err      = dec_in.err;
   end

   // wrong-path entries are consumed without waiting on the result side.
   assign on_path   = (dec_in.pc == expected_pc);
   assign res_valid = dec_valid & on_path;
   assign dec_ready = on_path ? res_ready : 1'b1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         expected_pc <= `EX_RESET_PC;
      end else if (res_valid && res_ready) begin
         expected_pc <= res_out.new_pc;
      end
   end

endmodule

`default_nettype wire

//--- design/ex_result.sv
// --------------------
// eight-word register file, all zero after reset.
// writes only when the consumer takes a record.
// --------------------
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_result (
   input  wire logic                   clk,
   input  wire logic                   arst_n,
   input  ex_pipe_pkg::res_t           res_in,
   input  wire logic                   res_valid,
   input  wire logic                   res_ready,
   input  wire logic [`EX_RADDR_W-1:0] rs_addr,
   input  wire logic [`EX_RADDR_W-1:0] rt_addr,
   output logic [`EX_XLEN-1:0]         rs_val,
   output logic [`EX_XLEN-1:0]         rt_val
);

   logic [`EX_XLEN-1:0] regs [`EX_NREGS];
   logic                commit;

   // architectural state changes at the output handshake only.
   assign commit = res_valid & res_ready & res_in.we;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `EX_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (commit) begin
         regs[res_in.rd] <= res_in.value;
      end
   end

   // no write-through here, execute forwards the pending record instead.
   assign rs_val = regs[rs_addr];
   assign rt_val = regs[rt_addr];

endmodule

`default_nettype wire

//--- design/ex_core.sv
// --------------------
// decode, two stage registers, execute, result.
// res follows an accepted input by two edges.
// --------------------
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_core (
   input  wire logic                clk,
   input  wire logic                arst_n,
   input  wire logic                in_valid,
   output logic                     in_ready,
   input  ex_isa_pkg::instr_t       in_instr,
   input  wire logic [`EX_XLEN-1:0] in_pc,
   output logic                     res_valid,
   input  wire logic                res_ready,
   output ex_pipe_pkg::res_t        res
);

   import ex_pipe_pkg::*;

   dec_t                   dec_d;
   dec_t                   dec_q;
   res_t                   res_d;
   logic                   dec_valid;
   logic                   dec_ready;
   logic                   ex_valid;
   logic                   ex_ready;
   logic [`EX_RADDR_W-1:0] rs_addr;
   logic [`EX_RADDR_W-1:0] rt_addr;
   logic [`EX_XLEN-1:0]    rs_val;
   logic [`EX_XLEN-1:0]    rt_val;

   ex_decode u_decode (
      .instr (in_instr),
      .pc    (in_pc),
      .dec   (dec_d)
   );

   ex_pipe_reg #(.payload_t(dec_t)) u_dec_reg (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (dec_d),
      .out_valid (dec_valid),
      .out_ready (dec_ready),
      .out_data  (dec_q)
   );

   // forwarding source is the result register itself.
   ex_execute u_execute (
      .clk       (clk),
      .arst_n    (arst_n),
      .dec_in    (dec_q),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready),
      .rs_addr   (rs_addr),
      .rt_addr   (rt_addr),
      .rs_val    (rs_val),
      .rt_val    (rt_val),
      .fwd_valid (res_valid),
      .fwd       (res),
      .res_out   (res_d),
      .res_valid (ex_valid),
      .res_ready (ex_ready)
   );

   ex_pipe_reg #(.payload_t(res_t)) u_res_reg (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (ex_valid),
      .in_ready  (ex_ready),
      .in_data   (res_d),
      .out_valid (res_valid),
      .out_ready (res_ready),
      .out_data  (res)
   );

   ex_result u_result (
      .clk       (clk),
      .arst_n    (arst_n),
      .res_in    (res),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .rs_addr   (rs_addr),
      .rt_addr   (rt_addr),
      .rs_val    (rs_val),
      .rt_val    (rt_val)
   );

endmodule

`default_nettype wire

//--- verification/ex_core_sva.sv
// --------------------
// output handshake and reset checks, bound into ex_core.
// fail_cnt counts assertion failures.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module ex_core_sva (
   input  wire logic        clk,
   input  wire logic        arst_n,
   input  wire logic        in_ready,
   input  wire logic        res_valid,
   input  wire logic        res_ready,
   input  ex_pipe_pkg::res_t res
);

   int unsigned fail_cnt = 0;

   // a stalled record holds until taken.
   assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && !res_ready |=> res_valid && $stable(res))
   else begin
      $error("res changed while res_ready was low");
      fail_cnt++;
   end

   assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(res_valid))
   else begin
      $error("res_valid unknown");
      fail_cnt++;
   end

   // both stage registers empty right after reset.
   assert property (@(posedge clk) $rose(arst_n) |-> in_ready)
   else begin
      $error("in_ready low in the first cycle after reset");
      fail_cnt++;
   end

endmodule

bind ex_core ex_core_sva u_sva (
   .clk       (clk),
   .arst_n    (arst_n),
   .in_ready  (in_ready),
   .res_valid (res_valid),
   .res_ready (res_ready),
   .res       (res)
);

`default_nettype wire

//--- verification/ex_core_tb.sv
// --------------------
// random instruction stream against an in-order model of ex_core.
// value is compared only on records that write a register.
// --------------------
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_core_tb;

   import ex_isa_pkg::*;
   import ex_pipe_pkg::*;

   localparam int N_INSTR    = 400;
   localparam int CLK_PERIOD = 4;
   localparam int MSB        = `EX_XLEN - 1;

   logic                clk;
   logic                arst_n;
   logic                in_valid;
   logic                in_ready;
   instr_t              in_instr;
   logic [`EX_XLEN-1:0] in_pc;
   logic                res_valid;
   logic                res_ready;
   res_t                res;

   integer              seed = 18;
   logic [`EX_XLEN-1:0] model_regs [`EX_NREGS];
   logic [`EX_XLEN-1:0] model_pc;
   logic [2:0]          last_rd;
   res_t                exp_q [$];
   int                  mismatch_cnt = 0;
   int                  extra_cnt    = 0;
   int                  checked_cnt  = 0;
   int                  discard_cnt  = 0;

   ex_core u_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_instr  (in_instr),
      .in_pc     (in_pc),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res       (res)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic branch_taken(input logic [3:0] op, input logic [MSB:0] v);
      case (op)
         OP_BEQZ: return v == '0;
         OP_BNEZ: return v != '0;
         OP_BLTZ: return v[MSB];
         OP_BGEZ: return !v[MSB];
         default: return 1'b0;
      endcase
   endfunction

   // expected record from the ISA rules and the model registers.
   function automatic res_t predict(input logic [MSB:0] word, input logic [MSB:0] pc);
      res_t         r;
      logic [MSB:0] a;
      logic [MSB:0] b;
      logic [MSB:0] imm6;
      logic [MSB:0] imm9;
      a    = model_regs[word[8:6]];
      b    = model_regs[word[5:3]];
      imm6 = {{10{word[5]}}, word[5:0]};
      imm9 = {{7{word[8]}}, word[8:0]};
      r        = '0;
      r.pc     = pc;
      r.rd     = word[11:9];
      r.we     = (word[15:12] <= OP_ADDI);
      r.new_pc = pc + 16'd1;
      case (word[15:12])
         OP_ADD: begin
            r.value = a + b;
            r.ofl   = (a[MSB] == b[MSB]) && (r.value[MSB] != a[MSB]);
         end
         OP_SUB: begin
            r.value = a - b;
            r.ofl   = (a[MSB] != b[MSB]) && (r.value[MSB] != a[MSB]);
         end
         OP_AND: r.value = a & b;
         OP_OR:  r.value = a | b;
         OP_XOR: r.value = a ^ b;
         OP_SLL: r.value = a << b[3:0];
         OP_SRL: r.value = a >> b[3:0];
         OP_SRA: r.value = $signed(a) >>> b[3:0];
         OP_ADDI: begin
            r.value = a + imm6;
            r.ofl   = (a[MSB] == imm6[MSB]) && (r.value[MSB] != a[MSB]);
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            r.redirect = branch_taken(word[15:12], a);
            if (r.redirect) begin
               r.new_pc = pc + 16'd1 + imm6;
            end
         end
         OP_J: begin
            r.redirect = 1'b1;
            r.new_pc   = pc + 16'd1 + imm9;
         end
         OP_JR: begin
            r.redirect = 1'b1;
            r.new_pc   = a + imm6;
         end
         default: r.err = 1'b1;   // opcode 15.
      endcase
      return r;
   endfunction

   task automatic gen_instr(output logic [MSB:0] word, output logic [MSB:0] pc);
      logic [31:0] rnd;
      logic [31:0] rnd_pc;
      logic [2:0]  idx;
      logic        found;
      rnd    = $random(seed);
      rnd_pc = $random(seed);
      word   = rnd[15:0];
      found  = 1'b0;
      if (word[15:12] >= OP_BEQZ && word[15:12] <= OP_BGEZ) begin
         // steer rs so that taken and not taken both occur.
         for (int k = 0; k < `EX_NREGS; k++) begin
            idx = rnd[23:21] + 3'(k);
            if (!found && branch_taken(word[15:12], model_regs[idx]) == rnd[20]) begin
               word[8:6] = idx;
               found     = 1'b1;
            end
         end
      end else begin
         if (rnd[25:24] == 2'b00) begin
            word[8:6] = last_rd;   // dependent on the one before.
         end
         if (rnd[27:26] == 2'b00) begin
            word[5:3] = last_rd;
         end
      end
      if ((rnd_pc % 10) < 8) begin
         pc = model_pc;
      end else begin
         pc = model_pc ^ (rnd_pc[31:16] | 16'd1);   // never on path.
      end
   endtask

   task automatic model_accept(input logic [MSB:0] word, input logic [MSB:0] pc);
      res_t r;
      if (pc != model_pc) begin
         discard_cnt++;
      end else begin
         r = predict(word, pc);
         exp_q.push_back(r);
         model_pc = r.new_pc;
         if (r.we) begin
            model_regs[r.rd] = r.value;
         end
      end
      last_rd = word[11:9];
   endtask

   task automatic field_err(input string name, input logic [MSB:0] got, input logic [MSB:0] exp);
      $display("ERR %0t: %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
   endtask

   task automatic check_record(input res_t got, input res_t exp);
      if (got.pc != exp.pc)
         field_err("pc", got.pc, exp.pc);
      if (got.rd != exp.rd)
         field_err("rd", 16'(got.rd), 16'(exp.rd));
      if (got.we != exp.we)
         field_err("we", 16'(got.we), 16'(exp.we));
      if (exp.we && got.value != exp.value)
         field_err("value", got.value, exp.value);
      if (got.ofl != exp.ofl)
         field_err("ofl", 16'(got.ofl), 16'(exp.ofl));
      if (got.redirect != exp.redirect)
         field_err("redirect", 16'(got.redirect), 16'(exp.redirect));
      if (got.new_pc != exp.new_pc)
         field_err("new_pc", got.new_pc, exp.new_pc);
      if (got.err != exp.err)
         field_err("err", 16'(got.err), 16'(exp.err));
   endtask

   // consumer side, about 70% ready.
   initial begin
      logic next_ready;
      res_ready = 1'b0;
      forever begin
         @(negedge clk);
         next_ready = (($unsigned($random(seed)) % 10) < 7);
         @(posedge clk);
         res_ready <= next_ready;
      end
   end

   // handshake seen mid-cycle completes at the next rising edge.
   always @(negedge clk) begin
      if (arst_n && res_valid && res_ready) begin
         if (exp_q.size() == 0) begin
            $display("unexpected result record at %0t with pc %h", $time, res.pc);
            extra_cnt++;
         end else begin
            check_record(res, exp_q.pop_front());
            checked_cnt++;
         end
      end
   end

   initial begin
      #(N_INSTR * 10 * CLK_PERIOD);
      $display("timeout: the run hung with %0d results still expected", exp_q.size());
      $display("test failed");
      $finish;
   end

   initial begin
      logic [MSB:0] word;
      logic [MSB:0] pc;
      logic [31:0]  gap;
      int           total;
      arst_n   = 1'b0;
      in_valid = 1'b0;
      in_instr = '0;
      in_pc    = '0;
      model_pc = `EX_RESET_PC;
      last_rd  = '0;
      for (int i = 0; i < `EX_NREGS; i++) begin
         model_regs[i] = '0;
      end
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      for (int n = 0; n < N_INSTR; n++) begin
         gen_instr(word, pc);
         in_valid <= 1'b1;
         in_instr <= word;
         in_pc    <= pc;
         @(negedge clk);
         while (!in_ready) begin
            @(negedge clk);
         end
         @(posedge clk);   // transfer edge.
         model_accept(word, pc);
         gap = $random(seed);
         if (gap[2:0] == 3'd0) begin
            in_valid <= 1'b0;
            @(posedge clk);
         end
      end
      in_valid <= 1'b0;
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      total = mismatch_cnt + extra_cnt + int'(u_dut.u_sva.fail_cnt);
      $display("errors: %0d mismatches, %0d unexpected, %0d assertion (%0d checked, %0d dropped)",
               mismatch_cnt, extra_cnt, u_dut.u_sva.fail_cnt, checked_cnt, discard_cnt);
      if (total == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- ex_core.f
+incdir+design
design/ex_isa_pkg.sv
design/ex_pipe_pkg.sv
design/ex_pipe_reg.sv
design/ex_decode.sv
design/ex_alu.sv
design/ex_execute.sv
design/ex_result.sv
design/ex_core.sv
verification/ex_core_sva.sv
verification/ex_core_tb.sv

//--- Makefile
# Verilator build and run of the ex_core testbench.
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module ex_core_tb \
		-Mdir $(OBJ_DIR) -f ex_core.f

run: compile
	./$(OBJ_DIR)/Vex_core_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
